// File: core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Integer register and data path width
`define XLEN 64

// Architectural registers x0 to x31
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif

// File: rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes of the supported RV64I subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011, // lb lh lw lbu lhu
        opStore  = 7'b0100011, // sb sh sw
        opBranch = 7'b1100011, // beq through bgeu
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111,
        opImm    = 7'b0010011, // addi and friends
        opReg    = 7'b0110011, // Register to register ops
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeE;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        fByte  = 3'b000,
        fHalf  = 3'b001,
        fWord  = 3'b010,
        fByteU = 3'b100, // Loads only
        fHalfU = 3'b101  // Loads only
    } ldStFunct3E;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        fBeq  = 3'b000,
        fBne  = 3'b001,
        fBlt  = 3'b100,
        fBge  = 3'b101,
        fBltu = 3'b110,
        fBgeu = 3'b111
    } branchFunct3E;

endpackage

`default_nettype wire

// File: coreCtrlPkg.sv
`default_nettype none

package coreCtrlPkg;

    // ALU operation codes
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSub   = 4'b0001,
        aluSlt   = 4'b0011,
        aluSltu  = 4'b0100,
        aluXor   = 4'b0101,
        aluSll   = 4'b0110, // Register and immediate forms share it
        aluSra   = 4'b0111,
        aluOr    = 4'b1000,
        aluAnd   = 4'b1001,
        aluPassB = 4'b1010, // lui
        aluSrl   = 4'b1011,
        aluBad   = 4'b1111  // Unknown encoding
    } aluOpE;

    // Branch condition, unsigned compares kept apart
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brEq   = 3'b001,
        brNe   = 3'b010,
        brLt   = 3'b011,
        brGe   = 3'b100,
        brLtu  = 3'b101,
        brGeu  = 3'b110
    } branchE;

    typedef enum logic [1:0] {
        jmpNone = 2'b00,
        jmpJal  = 2'b01,
        jmpJalr = 2'b10
    } jmpE;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu       = 2'b00,
        wbMem       = 2'b01, // Extended load data
        wbPcPlus4   = 2'b10, // Link of jal and jalr
        wbPcPlusImm = 2'b11  // auipc
    } wbSelE;

endpackage

`default_nettype wire

// File: muxKeyWithDefault.sv
`timescale 1ns/1ns
`default_nettype none

// Lookup table mux
// Each pair in lut is {key, data} and the first listed pair sits at the top
module muxKeyWithDefault #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    output logic [DATA_LEN-1:0]                  out,
    input  logic [KEY_LEN-1:0]                   key,
    input  logic [DATA_LEN-1:0]                  defaultOut,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    always_comb begin
        out = defaultOut; // No key hit
        for (int i = 0; i < NR_KEY; i++) begin
            // Key sits above its data within the pair
            if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*PAIR_LEN +: DATA_LEN];
            end
        end
    end

endmodule

`default_nettype wire

// File: controller.sv
`timescale 1ns/1ns
`default_nettype none

module controller
    import rvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  logic [31:0] instr,
    output aluOpE       aluOp,
    output logic        aluSrc,   // Operand b from imm
    output branchE      branch,
    output jmpE         jmp,
    output wbSelE       wbSel,
    output logic        regWrite,
    output logic        memWrite, // Store
    output logic [2:0]  dataLen,  // Bytes moved
    output logic        dataSign  // Sign-extend the load
);

    // How the ALU op is picked
    typedef enum logic [1:0] {
        clsAdd = 2'b00, // Address and jalr target
        clsSub = 2'b01, // Branches
        clsImm = 2'b10, // funct3 and shift field
        clsReg = 2'b11  // funct3 and funct7
    } aluClassE;

    opcodeE      opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [5:0]  funct6; // RV64 shifts have 6-bit shamt
    logic [1:0]  wbSelRaw;
    logic [2:0]  branchRaw;
    logic [1:0]  jmpRaw;
    logic [1:0]  aluClassRaw;
    logic [3:0]  regOpRaw;
    logic [3:0]  immBaseRaw;
    logic [3:0]  immShiftRaw;

    assign opcode = opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];

    muxKeyWithDefault #(4, 7, 2) muxWbSel (
        .out(wbSelRaw), .key(opcode), .defaultOut(wbAlu),
        .lut({opLoad, wbMem, opJalr, wbPcPlus4, opJal, wbPcPlus4, opAuipc, wbPcPlusImm})
    );
    assign wbSel = wbSelE'(wbSelRaw);

    muxKeyWithDefault #(1, 7, 1) muxMemWrite (
        .out(memWrite), .key(opcode), .defaultOut(1'b0), .lut({opStore, 1'b1})
    );

    // Opcode and funct3 together pick the condition
    muxKeyWithDefault #(6, 10, 3) muxBranch (
        .out(branchRaw), .key({opcode, funct3}), .defaultOut(brNone),
        .lut({opBranch, fBeq, brEq,   opBranch, fBne, brNe,
              opBranch, fBlt, brLt,   opBranch, fBge, brGe,
              opBranch, fBltu, brLtu, opBranch, fBgeu, brGeu})
    );
    assign branch = branchE'(branchRaw);

    muxKeyWithDefault #(2, 7, 2) muxJmp (
        .out(jmpRaw), .key(opcode), .defaultOut(jmpNone),
        .lut({opJal, jmpJal, opJalr, jmpJalr})
    );
    assign jmp = jmpE'(jmpRaw);

    muxKeyWithDefault #(5, 7, 2) muxAluClass (
        .out(aluClassRaw), .key(opcode), .defaultOut(clsAdd),
        .lut({opLoad, clsAdd, opStore, clsAdd, opBranch, clsSub, opImm, clsImm, opReg, clsReg})
    );

    // R-type ops
    muxKeyWithDefault #(10, 10, 4) muxRegOp (
        .out(regOpRaw), .key({funct7, funct3}), .defaultOut(aluBad),
        .lut({7'b0000000, 3'b000, aluAdd,  7'b0100000, 3'b000, aluSub,
              7'b0000000, 3'b001, aluSll,  7'b0000000, 3'b010, aluSlt,
              7'b0000000, 3'b011, aluSltu, 7'b0000000, 3'b100, aluXor,
              7'b0000000, 3'b101, aluSrl,  7'b0100000, 3'b101, aluSra,
              7'b0000000, 3'b110, aluOr,   7'b0000000, 3'b111, aluAnd})
    );

    // Immediate ops whose upper bits are all immediate
    muxKeyWithDefault #(6, 3, 4) muxImmBase (
        .out(immBaseRaw), .key(funct3), .defaultOut(aluBad),
        .lut({3'b000, aluAdd, 3'b010, aluSlt, 3'b011, aluSltu,
              3'b100, aluXor, 3'b110, aluOr,  3'b111, aluAnd})
    );

    // Immediate shifts also check the funct6 field
    muxKeyWithDefault #(3, 9, 4) muxImmShift (
        .out(immShiftRaw), .key({funct6, funct3}), .defaultOut(aluBad),
        .lut({6'b000000, 3'b001, aluSll, 6'b000000, 3'b101, aluSrl,
              6'b010000, 3'b101, aluSra})
    );

    always_comb begin
        unique case (aluClassE'(aluClassRaw))
            clsAdd:  aluOp = aluAdd;
            clsSub:  aluOp = aluSub;
            clsImm:  aluOp = (funct3 == 3'b001 || funct3 == 3'b101) ?
                             aluOpE'(immShiftRaw) : aluOpE'(immBaseRaw);
            default: aluOp = aluOpE'(regOpRaw);
        endcase
        if (opcode == opLui) begin
            aluOp = aluPassB; // Result is the U immediate
        end
    end

    muxKeyWithDefault #(5, 7, 1) muxAluSrc (
        .out(aluSrc), .key(opcode), .defaultOut(1'b0),
        .lut({opLoad, 1'b1, opStore, 1'b1, opImm, 1'b1, opLui, 1'b1, opJalr, 1'b1})
    );

    muxKeyWithDefault #(7, 7, 1) muxRegWrite (
        .out(regWrite), .key(opcode), .defaultOut(1'b0),
        .lut({opReg, 1'b1, opLoad, 1'b1, opImm, 1'b1, opJalr, 1'b1,
              opLui, 1'b1, opAuipc, 1'b1, opJal, 1'b1})
    );

    always_comb begin
        case (ldStFunct3E'(funct3))
            fByte, fByteU: dataLen = 3'd1;
            fHalf, fHalfU: dataLen = 3'd2;
            fWord:         dataLen = 3'd4;
            default:       dataLen = 3'd0; // Not a memory width
        endcase
    end

    // lw sign-extends as well on RV64
    assign dataSign = (opcode == opLoad) && (funct3 == fByte || funct3 == fHalf || funct3 == fWord);

endmodule

`default_nettype wire

// File: immGen.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module immGen
    import rvIsaPkg::*;
(
    input  logic [31:0]       instr,
    output logic [`XLEN-1:0]  imm
);

    logic sgn; // Every format takes its sign from bit 31

    assign sgn = instr[31];

    always_comb begin
        unique case (opcodeE'(instr[6:0]))
            // I format
            opLoad, opImm, opJalr: begin
                imm = {{(`XLEN-12){sgn}}, instr[31:20]};
            end
            // S format splits the immediate around rd
            opStore: begin
                imm = {{(`XLEN-12){sgn}}, instr[31:25], instr[11:7]};
            end
            // B format in units of two bytes
            opBranch: begin
                imm = {{(`XLEN-13){sgn}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            opLui, opAuipc: begin
                imm = {{(`XLEN-32){sgn}}, instr[31:12], 12'b0}; // Upper 20 bits
            end
            // J format
            opJal: begin
                imm = {{(`XLEN-21){sgn}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and unknown opcodes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module alu
    import coreCtrlPkg::*;
(
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  aluOpE            aluOp,
    output logic [`XLEN-1:0] result
);

    logic [5:0] shamt;    // Low 6 bits of b
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[5:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        unique case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSlt:   result = {{(`XLEN-1){1'b0}}, ltSigned};
            aluSltu:  result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            aluXor:   result = a ^ b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt; // Logical
            aluSra:   result = $signed(a) >>> shamt;
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluPassB: result = b;
            default:  result = '0; // aluBad included
        endcase
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module regFile (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1Addr,
    input  logic [$clog2(`REG_COUNT)-1:0] rs2Addr,
    input  logic [$clog2(`REG_COUNT)-1:0] rdAddr,
    input  logic [`XLEN-1:0]              rdData,
    input  logic                          writeEn,
    output logic [`XLEN-1:0]              rs1Data,
    output logic [`XLEN-1:0]              rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAddr != '0) begin
            regs[rdAddr] <= rdData; // x0 stays zero
        end
    end

    // Combinational reads see last edge's write
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: rvCore.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module rvCore
    import coreCtrlPkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    output logic [`XLEN-1:0]  instrAddr,
    input  logic [31:0]       instr,
    output logic [`XLEN-1:0]  dataAddr,
    output logic [`XLEN-1:0]  dataWdata,
    input  logic [`XLEN-1:0]  dataRdata, // Low-justified
    output logic              dataWrite, // Strobe at the next edge
    output logic [2:0]        dataLen,
    output logic              dataRead   // Level for loads
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] wbData;
    aluOpE            aluOp;
    branchE           branch;
    jmpE              jmp;
    wbSelE            wbSel;
    logic             aluSrc;
    logic             regWrite;
    logic             memWrite;
    logic             dataSign;
    logic             brTaken;

    controller uCtrl (
        .instr(instr), .aluOp(aluOp), .aluSrc(aluSrc), .branch(branch), .jmp(jmp),
        .wbSel(wbSel), .regWrite(regWrite), .memWrite(memWrite), .dataLen(dataLen),
        .dataSign(dataSign)
    );

    immGen uImm (.instr(instr), .imm(imm));

    regFile uRegs (
        .clk(clk), .arstN(arstN), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rdAddr(instr[11:7]), .rdData(wbData), .writeEn(regWrite & arstN),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu uAlu (.a(rs1Data), .b(aluSrc ? imm : rs2Data), .aluOp(aluOp), .result(aluResult));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) pc <= `RESET_PC;
        else        pc <= nextPc;
    end

    // Branch compare straight from the register operands
    always_comb begin
        unique case (branch)
            brEq:    brTaken = rs1Data == rs2Data;
            brNe:    brTaken = rs1Data != rs2Data;
            brLt:    brTaken = $signed(rs1Data) < $signed(rs2Data);
            brGe:    brTaken = $signed(rs1Data) >= $signed(rs2Data);
            brLtu:   brTaken = rs1Data < rs2Data;
            brGeu:   brTaken = rs1Data >= rs2Data;
            default: brTaken = 1'b0;
        endcase
    end

    assign pcPlus4   = pc + `XLEN'd4;
    assign pcPlusImm = pc + imm; // Branch, jal and auipc target
    assign nextPc    = (jmp == jmpJalr) ? {aluResult[`XLEN-1:1], 1'b0} :
                       (jmp == jmpJal || brTaken) ? pcPlusImm : pcPlus4;

    always_comb begin
        unique case (dataLen)
            3'd1:    loadData = {{(`XLEN-8){dataSign & dataRdata[7]}}, dataRdata[7:0]};
            3'd2:    loadData = {{(`XLEN-16){dataSign & dataRdata[15]}}, dataRdata[15:0]};
            3'd4:    loadData = {{(`XLEN-32){dataSign & dataRdata[31]}}, dataRdata[31:0]};
            default: loadData = dataRdata;
        endcase
        unique case (wbSel)
            wbMem:       wbData = loadData;
            wbPcPlus4:   wbData = pcPlus4; // Link
            wbPcPlusImm: wbData = pcPlusImm;
            default:     wbData = aluResult;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult; // rs1 plus offset
    assign dataWdata = rs2Data;
    assign dataWrite = memWrite & arstN; // No stores while held in reset
    assign dataRead  = (wbSel == wbMem);

endmodule

`default_nettype wire

// File: tbRvCore.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module tbRvCore
    import rvIsaPkg::*;
();

    localparam int timeoutCycles = 50;
    // R-type table in funct3 order with alt marking sub and sra
    localparam logic [2:0] opF3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                          3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic       opAlt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                          1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    localparam logic [2:0] brF3  [6]  = '{fBeq, fBne, fBlt, fBge, fBltu, fBgeu};
    localparam logic [2:0] ldF3  [4]  = '{fByte, fHalf, fByteU, fHalfU};

    logic              clk = 1'b0;
    logic              arstN;
    logic [`XLEN-1:0]  instrAddr;
    logic [31:0]       instr;
    logic [`XLEN-1:0]  dataAddr;
    logic [`XLEN-1:0]  dataWdata;
    logic [`XLEN-1:0]  dataRdata;
    logic              dataWrite;
    logic [2:0]        dataLen;
    logic              dataRead;
    logic [31:0]       imem [256];
    logic [7:0]        dmem [256];
    logic [7:0]        seedMem [256]; // Image copied into dmem during reset
    logic [7:0]        dIdx;
    int                pcIdx;
    int                checks = 0;
    int                errors = 0;

    rvCore u_rvCore (
        .clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataRdata(dataRdata),
        .dataWrite(dataWrite), .dataLen(dataLen), .dataRead(dataRead)
    );

    always #20 clk = ~clk;

    assign instr = imem[instrAddr[9:2]];
    assign dIdx  = dataAddr[7:0];
    assign dataRdata = {dmem[dIdx + 8'd7], dmem[dIdx + 8'd6], dmem[dIdx + 8'd5], dmem[dIdx + 8'd4],
                        dmem[dIdx + 8'd3], dmem[dIdx + 8'd2], dmem[dIdx + 8'd1], dmem[dIdx]};

    // Byte-wide data memory writing dataLen low bytes per strobe
    always @(posedge clk) begin
        if (!arstN) begin
            dmem <= seedMem;
        end else if (dataWrite) begin
            for (int k = 0; k < 8; k++) begin
                if (3'(k) < dataLen) dmem[dIdx + 8'(k)] <= dataWdata[8*k +: 8];
            end
        end
    end

    // Instruction encoders
    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, opcodeE op);
        return {imm, rs1, f3, rd, op};
    endfunction
    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction
    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction
    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction
    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic logic [63:0] sx32(logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction
    function automatic logic [63:0] sx12(logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction
    function automatic logic [7:0] fillByte(logic [7:0] a);
        return {a[3:0], a[7:4]} ^ 8'h3C; // Nibble swap over the whole address
    endfunction

    // RV64I integer op by funct3 with shifts by the low 6 bits
    function automatic logic [63:0] refOp(logic [2:0] f3, logic alt, logic [63:0] a,
                                          logic [63:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'd0, $signed(a) < $signed(b)};
            3'd3:    return {63'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic brRef(logic [2:0] f3, logic [63:0] a, logic [63:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [63:0] loadRef(logic [2:0] f3, logic [31:0] w);
        case (f3)
            3'b000:  return {{56{w[7]}}, w[7:0]};   // lb
            3'b001:  return {{48{w[15]}}, w[15:0]}; // lh
            3'b100:  return {56'd0, w[7:0]};
            default: return {48'd0, w[15:0]};
        endcase
    endfunction

    // Eight bytes from addr with the low n replaced by w
    function automatic logic [63:0] mergeRef(logic [7:0] addr, logic [31:0] w, int n);
        logic [63:0] r;
        for (int j = 0; j < 8; j++) begin
            r[8*j +: 8] = (j < n) ? w[8*j +: 8] : fillByte(addr + 8'(j));
        end
        return r;
    endfunction

    function automatic logic [63:0] memDword(logic [7:0] addr);
        logic [63:0] r;
        for (int j = 0; j < 8; j++) r[8*j +: 8] = dmem[addr + 8'(j)];
        return r;
    endfunction

    task automatic checkWord(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                             input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkLen(input logic [2:0] got, input logic [2:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic checkPc(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                           input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Checks %0d, errors %0d, run aborted", checks, errors + 1);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // Enter reset and clear imem to self-loops
    task automatic beginProgram();
        @(posedge clk);
        #2 arstN = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = encJ(21'd0, 5'd0);
        pcIdx = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[pcIdx] = word;
        pcIdx++;
    endtask

    task automatic releaseReset();
        repeat (3) @(posedge clk);
        #2 arstN = 1'b1;
    endtask

    task automatic putWord(input logic [7:0] addr, input logic [31:0] w);
        for (int j = 0; j < 4; j++) seedMem[addr + 8'(j)] = w[8*j +: 8];
    endtask

    // Sampled at negedge where the core outputs are settled
    task automatic waitStore();
        int n;
        n = 0;
        @(negedge clk);
        while (!dataWrite && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (!dataWrite) abortRun("No store seen within the timeout");
    endtask

    task automatic testReset();
        beginProgram();
        emit(encS(12'h090, 5'd0, 5'd0, fWord)); // Would strobe if not gated
        repeat (3) begin
            @(negedge clk);
            checkPc(instrAddr, `RESET_PC, "instrAddr in reset");
            checkFlag(dataWrite, 1'b0, "dataWrite in reset");
        end
        releaseReset();
        @(negedge clk);
        checkPc(instrAddr, `RESET_PC, "instrAddr after release");
        @(negedge clk);
        checkPc(instrAddr, `RESET_PC + 64'd4, "instrAddr one edge after release");
    endtask

    task automatic testRegOps();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom;
        b = $urandom;
        beginProgram();
        putWord(8'h80, a);
        putWord(8'h84, b);
        emit(encI(12'h080, 5'd0, fWord, 5'd1, opLoad));
        emit(encI(12'h084, 5'd0, fWord, 5'd2, opLoad));
        for (int i = 0; i < 10; i++) begin
            emit(encR({1'b0, opAlt[i], 5'd0}, 5'd2, 5'd1, opF3[i], 5'd3));
            emit(encS(12'h090, 5'd3, 5'd0, fWord));
        end
        releaseReset();
        for (int i = 0; i < 10; i++) begin
            waitStore();
            checkWord(dataWdata, refOp(opF3[i], opAlt[i], sx32(a), sx32(b)),
                      $sformatf("dataWdata reg op %0d", i));
            checkLen(dataLen, 3'd4, "dataLen sw");
        end
    endtask

    task automatic testImmOps();
        logic [31:0] a;
        logic [11:0] imms [10];
        logic [19:0] upper;
        a     = $urandom;
        upper = 20'($urandom);
        beginProgram();
        putWord(8'h80, a);
        emit(encI(12'h080, 5'd0, fWord, 5'd1, opLoad));
        for (int i = 0; i < 10; i++) begin
            // Shifts carry funct6 above a 6-bit shamt
            imms[i] = (opF3[i] == 3'd1 || opF3[i] == 3'd5) ?
                      {1'b0, opAlt[i], 4'd0, 6'($urandom)} : 12'($urandom);
            if (i != 1) begin
                emit(encI(imms[i], 5'd1, opF3[i], 5'd3, opImm));
                emit(encS(12'h090, 5'd3, 5'd0, fWord));
            end
        end
        emit({upper, 5'd3, opLui});
        emit(encS(12'h090, 5'd3, 5'd0, fWord));
        releaseReset();
        for (int i = 0; i < 10; i++) begin
            if (i != 1) begin
                waitStore();
                checkWord(dataWdata, refOp(opF3[i], opAlt[i], sx32(a), sx12(imms[i])),
                          $sformatf("dataWdata imm op %0d", i));
            end
        end
        waitStore();
        checkWord(dataWdata, sx32({upper, 12'd0}), "dataWdata lui");
    endtask

    task automatic testLoadStore();
        logic [31:0] w;
        w = $urandom | 32'h8000_8080; // Sign bits set at every width
        beginProgram();
        putWord(8'h80, w);
        emit(encI(12'h080, 5'd0, fWord, 5'd1, opLoad));
        emit(encS(12'h0A0, 5'd1, 5'd0, fByte));
        emit(encS(12'h0A8, 5'd1, 5'd0, fHalf));
        emit(encS(12'h0B0, 5'd1, 5'd0, fWord));
        for (int i = 0; i < 4; i++) begin
            emit(encI(12'h080, 5'd0, ldF3[i], 5'd2, opLoad));
            emit(encS(12'h090, 5'd2, 5'd0, fWord));
        end
        releaseReset();
        @(negedge clk);
        checkFlag(dataRead, 1'b1, "dataRead on lw"); // Core sits on the first load
        for (int k = 0; k < 3; k++) begin
            waitStore();
            checkFlag(dataRead, 1'b0, "dataRead on store");
            checkLen(dataLen, 3'(1 << k), $sformatf("dataLen store %0d", k));
            if (k == 2) checkWord(dataWdata, sx32(w), "dataWdata after lw");
            @(posedge clk);
            #1 checkWord(memDword(8'(8'hA0 + 8 * k)), mergeRef(8'(8'hA0 + 8 * k), w, 1 << k),
                         $sformatf("memory bytes store %0d", k));
        end
        for (int i = 0; i < 4; i++) begin
            waitStore();
            checkWord(dataWdata, loadRef(ldF3[i], w), $sformatf("dataWdata load %0d", i));
        end
    endtask

    // Marker 2 on the target path and 1 on fall-through
    task automatic runBranch(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
        beginProgram();
        putWord(8'h80, a);
        putWord(8'h84, b);
        emit(encI(12'h080, 5'd0, fWord, 5'd1, opLoad));
        emit(encI(12'h084, 5'd0, fWord, 5'd2, opLoad));
        emit(encB(13'd12, 5'd2, 5'd1, f3));
        emit(encI(12'd1, 5'd0, 3'd0, 5'd3, opImm));
        emit(encJ(21'd8, 5'd0));
        emit(encI(12'd2, 5'd0, 3'd0, 5'd3, opImm));
        emit(encS(12'h090, 5'd3, 5'd0, fWord));
        releaseReset();
        waitStore();
        checkWord(dataWdata, brRef(f3, sx32(a), sx32(b)) ? 64'd2 : 64'd1,
                  $sformatf("dataWdata branch f3 %0d a %h b %h", f3, a, b));
    endtask

    task automatic testBranches();
        logic [31:0] neg;
        logic [31:0] pos;
        neg = $urandom | 32'h8000_0000;
        pos = ($urandom & 32'h7FFF_FFFF) | 32'd1;
        for (int i = 0; i < 6; i++) begin
            runBranch(brF3[i], neg, pos);
            runBranch(brF3[i], pos, neg);
            runBranch(brF3[i], pos, pos);
        end
    endtask

    task automatic testJumps();
        beginProgram();
        emit(encI(12'h055, 5'd0, 3'd0, 5'd0, opImm)); // Lost in x0
        emit(encS(12'h090, 5'd0, 5'd0, fWord));
        emit({20'h80001, 5'd5, opAuipc});               // At pc 8
        emit(encS(12'h090, 5'd5, 5'd0, fWord));
        emit(encJ(21'd16, 5'd6));                       // 16 to 32
        pcIdx = 8;
        emit(encS(12'h090, 5'd6, 5'd0, fWord));
        emit(encI(12'h031, 5'd0, 3'd0, 5'd7, opImm));
        emit(encI(12'h010, 5'd7, 3'd0, 5'd8, opJalr));  // 0x41 with bit 0 dropped
        pcIdx = 16;
        emit(encS(12'h090, 5'd8, 5'd0, fWord));
        releaseReset();
        waitStore();
        checkWord(dataWdata, 64'd0, "dataWdata x0");
        waitStore();
        checkWord(dataWdata, 64'd8 + sx32(32'h8000_1000), "dataWdata auipc");
        waitStore();
        checkPc(instrAddr, 64'd32, "instrAddr after jal");
        checkWord(dataWdata, 64'd20, "dataWdata jal link");
        waitStore();
        checkPc(instrAddr, 64'd64, "instrAddr after jalr");
        checkWord(dataWdata, 64'd44, "dataWdata jalr link");
    endtask

    initial begin
        arstN = 1'b0;
        void'($urandom(60));
        for (int i = 0; i < 256; i++) seedMem[i] = fillByte(8'(i));
        for (int i = 0; i < 256; i++) imem[i] = encJ(21'd0, 5'd0);
        testReset();
        testRegOps();
        testImmOps();
        testLoadStore();
        testBranches();
        testJumps();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
rvIsaPkg.sv
coreCtrlPkg.sv
muxKeyWithDefault.sv
controller.sv
immGen.sv
alu.sv
regFile.sv
rvCore.sv
tbRvCore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tbRvCore -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
